// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

	// Default geometry of the cache and its backing store.
	// Word address width, in bits.
	parameter int DEF_ADDR_WIDTH = 12;

	// Processor word width, in bits.
	parameter int DEF_DATA_WIDTH = 32;

	// One line is four words.
	parameter int DEF_BLOCK_SIZE = 128;

	// Capacity in bytes, 16 lines.
	parameter int DEF_CACHE_SIZE = 256;

	// Cycles from a memory strobe to its mem_done pulse.
	parameter int DEF_MEM_LATENCY = 4;

	// Controller states.
	typedef enum logic [2:0] {
		ST_IDLE      = 3'd0,
		ST_LOOKUP    = 3'd1,
		ST_WRITEBACK = 3'd2,
		ST_REFILL    = 3'd3,
		ST_UPDATE    = 3'd4
	} cache_state_t;

endpackage

`default_nettype wire

// ==== cache_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_memory #(
	parameter int ADDR_WIDTH = cache_pkg::DEF_ADDR_WIDTH,
	parameter int DATA_WIDTH = cache_pkg::DEF_DATA_WIDTH,
	parameter int BLOCK_SIZE = cache_pkg::DEF_BLOCK_SIZE,
	parameter int CACHE_SIZE = cache_pkg::DEF_CACHE_SIZE
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [BLOCK_SIZE-1:0] data_write,
	input  logic                  dirty_write,
	input  logic                  write_en,
	output logic [BLOCK_SIZE-1:0] data_read,
	output logic                  dirty_read,
	output logic                  hit,
	output logic [ADDR_WIDTH-$clog2(BLOCK_SIZE/DATA_WIDTH)-$clog2((CACHE_SIZE*8)/BLOCK_SIZE)-1:0]
	                              replace_tag
);

	localparam int NUM_BLOCKS   = (CACHE_SIZE * 8) / BLOCK_SIZE;
	localparam int OFFSET_WIDTH = $clog2(BLOCK_SIZE / DATA_WIDTH);
	localparam int INDEX_WIDTH  = $clog2(NUM_BLOCKS);
	localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// Line storage, one entry per index.
	logic [BLOCK_SIZE-1:0] data_mem [NUM_BLOCKS];
	logic [TAG_WIDTH-1:0]  tag_mem  [NUM_BLOCKS];
	logic [NUM_BLOCKS-1:0] valid_bits;
	logic [NUM_BLOCKS-1:0] dirty_bits;

	// Line registered from the index of the previous edge.
	logic [BLOCK_SIZE-1:0] data_q;
	logic [TAG_WIDTH-1:0]  tag_q;
	logic                  valid_q;
	logic                  dirty_q;

	logic [TAG_WIDTH-1:0]   addr_tag;
	logic [INDEX_WIDTH-1:0] addr_index;

	assign addr_tag   = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
	assign addr_index = addr[OFFSET_WIDTH +: INDEX_WIDTH];

	assign data_read   = data_q;
	assign dirty_read  = dirty_q;
	assign replace_tag = tag_q;

	// Stored tag against the tag of the address presented now.
	assign hit = valid_q && (tag_q == addr_tag);

	// Valid and dirty flags.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_bits <= '0;
			dirty_bits <= '0;
			valid_q    <= 1'b0;
			dirty_q    <= 1'b0;
		end else begin
			valid_q <= valid_bits[addr_index];
			dirty_q <= dirty_bits[addr_index];
			if (write_en) begin
				valid_bits[addr_index] <= 1'b1;
				dirty_bits[addr_index] <= dirty_write;
			end
		end
	end

	// Data and tag arrays.
	always_ff @(posedge clk) begin
		data_q <= data_mem[addr_index];
		tag_q  <= tag_mem[addr_index];
		if (write_en) begin
			data_mem[addr_index] <= data_write;
			tag_mem[addr_index]  <= addr_tag;
		end
	end

endmodule

`default_nettype wire

// ==== line_word_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_word_mux #(
	parameter int DATA_WIDTH = cache_pkg::DEF_DATA_WIDTH,
	parameter int BLOCK_SIZE = cache_pkg::DEF_BLOCK_SIZE
) (
	input  logic [BLOCK_SIZE-1:0]                      block,
	input  logic [$clog2(BLOCK_SIZE/DATA_WIDTH)-1:0] offset,
	input  logic [DATA_WIDTH-1:0]                      wdata,
	output logic [DATA_WIDTH-1:0]                      word,
	output logic [BLOCK_SIZE-1:0]                      merged
);

	localparam int NUM_WORDS    = BLOCK_SIZE / DATA_WIDTH;
	localparam int OFFSET_WIDTH = $clog2(NUM_WORDS);

	// Read side.
	assign word = block[offset*DATA_WIDTH +: DATA_WIDTH];

	// Only the addressed word takes wdata.
	for (genvar i = 0; i < NUM_WORDS; i++) begin : g_merge
		assign merged[i*DATA_WIDTH +: DATA_WIDTH] =
			(offset == OFFSET_WIDTH'(i)) ? wdata : block[i*DATA_WIDTH +: DATA_WIDTH];
	end

endmodule

`default_nettype wire

// ==== cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_controller #(
	parameter int ADDR_WIDTH = cache_pkg::DEF_ADDR_WIDTH,
	parameter int DATA_WIDTH = cache_pkg::DEF_DATA_WIDTH,
	parameter int BLOCK_SIZE = cache_pkg::DEF_BLOCK_SIZE,
	parameter int CACHE_SIZE = cache_pkg::DEF_CACHE_SIZE
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic                  ready,
	output logic                  done,
	output logic [DATA_WIDTH-1:0] rdata,
	output logic                  was_hit,

	output logic [ADDR_WIDTH-1:0] arr_addr,
	output logic [BLOCK_SIZE-1:0] arr_data_write,
	output logic                  arr_dirty_write,
	output logic                  arr_write_en,
	input  logic [BLOCK_SIZE-1:0] arr_data_read,
	input  logic                  arr_dirty_read,
	input  logic                  arr_hit,
	input  logic [ADDR_WIDTH-$clog2(BLOCK_SIZE/DATA_WIDTH)-$clog2((CACHE_SIZE*8)/BLOCK_SIZE)-1:0]
	                              arr_replace_tag,

	output logic [BLOCK_SIZE-1:0]                      mux_block,
	output logic [$clog2(BLOCK_SIZE/DATA_WIDTH)-1:0] mux_offset,
	output logic [DATA_WIDTH-1:0]                      mux_wdata,
	input  logic [DATA_WIDTH-1:0]                      mux_word,
	input  logic [BLOCK_SIZE-1:0]                      mux_merged,

	output logic                                                 mem_rd,
	output logic                                                 mem_wr,
	output logic [ADDR_WIDTH-$clog2(BLOCK_SIZE/DATA_WIDTH)-1:0] mem_addr,
	output logic [BLOCK_SIZE-1:0]                                mem_wdata,
	input  logic [BLOCK_SIZE-1:0]                                mem_rdata,
	input  logic                                                 mem_done
);

	import cache_pkg::*;

	localparam int NUM_BLOCKS   = (CACHE_SIZE * 8) / BLOCK_SIZE;
	localparam int OFFSET_WIDTH = $clog2(BLOCK_SIZE / DATA_WIDTH);
	localparam int INDEX_WIDTH  = $clog2(NUM_BLOCKS);
	localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	cache_state_t state;

	// Latched request.
	logic [ADDR_WIDTH-1:0] addr_q;
	logic                  we_q;
	logic [DATA_WIDTH-1:0] wdata_q;

	// Block fetched from memory, held for the update cycle.
	logic [BLOCK_SIZE-1:0] refill_q;

	logic [INDEX_WIDTH+TAG_WIDTH-1:0] block_addr;
	logic [INDEX_WIDTH+TAG_WIDTH-1:0] victim_addr;

	assign block_addr  = addr_q[ADDR_WIDTH-1:OFFSET_WIDTH];
	assign victim_addr = {arr_replace_tag, addr_q[OFFSET_WIDTH +: INDEX_WIDTH]};

	assign ready = (state == ST_IDLE);

	// The array sees the incoming address in idle so that the
	// line is already registered when the lookup cycle starts.
	assign arr_addr = (state == ST_IDLE) ? addr : addr_q;

	assign mux_block  = (state == ST_UPDATE) ? refill_q : arr_data_read;
	assign mux_offset = addr_q[OFFSET_WIDTH-1:0];
	assign mux_wdata  = wdata_q;

	// Write hit in lookup, or line install in update.
	assign arr_write_en    = (state == ST_LOOKUP && arr_hit && we_q) || (state == ST_UPDATE);
	assign arr_data_write  = (state == ST_UPDATE && !we_q) ? refill_q : mux_merged;
	assign arr_dirty_write = we_q;

	// FSM and strobes.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			done    <= 1'b0;
			was_hit <= 1'b0;
			mem_rd  <= 1'b0;
			mem_wr  <= 1'b0;
		end else begin
			done   <= 1'b0;
			mem_rd <= 1'b0;
			mem_wr <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (req) begin
						state <= ST_LOOKUP;
					end
				end
				ST_LOOKUP: begin
					if (arr_hit) begin
						done    <= 1'b1;
						was_hit <= 1'b1;
						state   <= ST_IDLE;
					end else if (arr_dirty_read) begin
						mem_wr <= 1'b1;
						state  <= ST_WRITEBACK;
					end else begin
						mem_rd <= 1'b1;
						state  <= ST_REFILL;
					end
				end
				ST_WRITEBACK: begin
					// Victim is in memory, now fetch the new line.
					if (mem_done) begin
						mem_rd <= 1'b1;
						state  <= ST_REFILL;
					end
				end
				ST_REFILL: begin
					if (mem_done) begin
						state <= ST_UPDATE;
					end
				end
				ST_UPDATE: begin
					done    <= 1'b1;
					was_hit <= 1'b0;
					state   <= ST_IDLE;
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// Request, memory address and data registers.
	always_ff @(posedge clk) begin
		case (state)
			ST_IDLE: begin
				if (req) begin
					addr_q  <= addr;
					we_q    <= we;
					wdata_q <= wdata;
				end
			end
			ST_LOOKUP: begin
				// A write returns the word it leaves in the line.
				rdata     <= we_q ? wdata_q : mux_word;
				mem_addr  <= arr_dirty_read ? victim_addr : block_addr;
				mem_wdata <= arr_data_read;
			end
			ST_WRITEBACK: begin
				if (mem_done) begin
					mem_addr <= block_addr;
				end
			end
			ST_REFILL: begin
				if (mem_done) begin
					refill_q <= mem_rdata;
				end
			end
			ST_UPDATE: begin
				rdata <= we_q ? wdata_q : mux_word;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== main_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_memory #(
	parameter int ADDR_WIDTH  = cache_pkg::DEF_ADDR_WIDTH,
	parameter int DATA_WIDTH  = cache_pkg::DEF_DATA_WIDTH,
	parameter int BLOCK_SIZE  = cache_pkg::DEF_BLOCK_SIZE,
	parameter int MEM_LATENCY = cache_pkg::DEF_MEM_LATENCY
) (
	input  logic                                                 clk,
	input  logic                                                 rst_n,
	input  logic                                                 mem_rd,
	input  logic                                                 mem_wr,
	input  logic [ADDR_WIDTH-$clog2(BLOCK_SIZE/DATA_WIDTH)-1:0] mem_addr,
	input  logic [BLOCK_SIZE-1:0]                                mem_wdata,
	output logic [BLOCK_SIZE-1:0]                                mem_rdata,
	output logic                                                 mem_done
);

	localparam int OFFSET_WIDTH = $clog2(BLOCK_SIZE / DATA_WIDTH);
	localparam int BADDR_WIDTH  = ADDR_WIDTH - OFFSET_WIDTH;
	localparam int DEPTH        = 1 << BADDR_WIDTH;
	localparam int CNT_WIDTH    = $clog2(MEM_LATENCY + 1);

	logic [BLOCK_SIZE-1:0] ram [DEPTH];

	// Request held while the latency runs.
	logic [BADDR_WIDTH-1:0] addr_q;
	logic [BLOCK_SIZE-1:0]  wdata_q;
	logic                   wr_q;
	logic [CNT_WIDTH-1:0]   cnt;

	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			ram[i] = '0;
		end
	end

	// Latency counter. MEM_LATENCY of two or more.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt      <= '0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= 1'b0;
			if (mem_rd || mem_wr) begin
				cnt <= CNT_WIDTH'(MEM_LATENCY - 1);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				if (cnt == CNT_WIDTH'(1)) begin
					mem_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_rd || mem_wr) begin
			addr_q  <= mem_addr;
			wdata_q <= mem_wdata;
			wr_q    <= mem_wr;
		end else if (cnt == CNT_WIDTH'(1)) begin
			if (wr_q) begin
				ram[addr_q] <= wdata_q;
			end else begin
				mem_rdata <= ram[addr_q];
			end
		end
	end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
	parameter int ADDR_WIDTH  = cache_pkg::DEF_ADDR_WIDTH,
	parameter int DATA_WIDTH  = cache_pkg::DEF_DATA_WIDTH,
	parameter int BLOCK_SIZE  = cache_pkg::DEF_BLOCK_SIZE,
	parameter int CACHE_SIZE  = cache_pkg::DEF_CACHE_SIZE,
	parameter int MEM_LATENCY = cache_pkg::DEF_MEM_LATENCY
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  req,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic                  ready,
	output logic                  done,
	output logic [DATA_WIDTH-1:0] rdata,
	output logic                  was_hit
);

	localparam int NUM_BLOCKS   = (CACHE_SIZE * 8) / BLOCK_SIZE;
	localparam int OFFSET_WIDTH = $clog2(BLOCK_SIZE / DATA_WIDTH);
	localparam int INDEX_WIDTH  = $clog2(NUM_BLOCKS);
	localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// Controller to array.
	logic [ADDR_WIDTH-1:0] arr_addr;
	logic [BLOCK_SIZE-1:0] arr_data_write;
	logic                  arr_dirty_write;
	logic                  arr_write_en;
	logic [BLOCK_SIZE-1:0] arr_data_read;
	logic                  arr_dirty_read;
	logic                  arr_hit;
	logic [TAG_WIDTH-1:0]  arr_replace_tag;

	// Controller to word mux.
	logic [BLOCK_SIZE-1:0]   mux_block;
	logic [OFFSET_WIDTH-1:0] mux_offset;
	logic [DATA_WIDTH-1:0]   mux_wdata;
	logic [DATA_WIDTH-1:0]   mux_word;
	logic [BLOCK_SIZE-1:0]   mux_merged;

	// Controller to backing memory.
	logic                             mem_rd;
	logic                             mem_wr;
	logic [TAG_WIDTH+INDEX_WIDTH-1:0] mem_addr;
	logic [BLOCK_SIZE-1:0]            mem_wdata;
	logic [BLOCK_SIZE-1:0]            mem_rdata;
	logic                             mem_done;

	cache_controller #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.CACHE_SIZE (CACHE_SIZE)
	) u_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.req             (req),
		.we              (we),
		.addr            (addr),
		.wdata           (wdata),
		.ready           (ready),
		.done            (done),
		.rdata           (rdata),
		.was_hit         (was_hit),
		.arr_addr        (arr_addr),
		.arr_data_write  (arr_data_write),
		.arr_dirty_write (arr_dirty_write),
		.arr_write_en    (arr_write_en),
		.arr_data_read   (arr_data_read),
		.arr_dirty_read  (arr_dirty_read),
		.arr_hit         (arr_hit),
		.arr_replace_tag (arr_replace_tag),
		.mux_block       (mux_block),
		.mux_offset      (mux_offset),
		.mux_wdata       (mux_wdata),
		.mux_word        (mux_word),
		.mux_merged      (mux_merged),
		.mem_rd          (mem_rd),
		.mem_wr          (mem_wr),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.mem_rdata       (mem_rdata),
		.mem_done        (mem_done)
	);

	cache_memory #(
		.ADDR_WIDTH (ADDR_WIDTH),
		.DATA_WIDTH (DATA_WIDTH),
		.BLOCK_SIZE (BLOCK_SIZE),
		.CACHE_SIZE (CACHE_SIZE)
	) u_array (
		.clk         (clk),
		.rst_n       (rst_n),
		.addr        (arr_addr),
		.data_write  (arr_data_write),
		.dirty_write (arr_dirty_write),
		.write_en    (arr_write_en),
		.data_read   (arr_data_read),
		.dirty_read  (arr_dirty_read),
		.hit         (arr_hit),
		.replace_tag (arr_replace_tag)
	);

	line_word_mux #(
		.DATA_WIDTH (DATA_WIDTH),
		.BLOCK_SIZE (BLOCK_SIZE)
	) u_mux (
		.block  (mux_block),
		.offset (mux_offset),
		.wdata  (mux_wdata),
		.word   (mux_word),
		.merged (mux_merged)
	);

	main_memory #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.DATA_WIDTH  (DATA_WIDTH),
		.BLOCK_SIZE  (BLOCK_SIZE),
		.MEM_LATENCY (MEM_LATENCY)
	) u_mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_rd    (mem_rd),
		.mem_wr    (mem_wr),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_done  (mem_done)
	);

endmodule

`default_nettype wire

// ==== cache_top_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top_props (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    req,
	input logic                    ready,
	input logic                    done,
	input logic                    mem_rd,
	input logic                    mem_wr,
	input cache_pkg::cache_state_t state
);

	import cache_pkg::*;

	// Failed assertions so far, read by the testbench.
	int error_count = 0;

	// done is a single-cycle pulse.
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			$error("done stayed high for more than one cycle");
			error_count++;
		end

	// One memory command at a time.
	a_mem_onehot: assert property (@(posedge clk) disable iff (!rst_n) !(mem_rd && mem_wr))
		else begin
			$error("mem_rd and mem_wr high in the same cycle");
			error_count++;
		end

	a_req_ready: assert property (@(posedge clk) disable iff (!rst_n) req |-> ready)
		else begin
			$error("req given while ready was low");
			error_count++;
		end

	// An accepted request leaves idle for lookup and drops ready
	a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n)
		ready && req |=> !ready && state == ST_LOOKUP)
		else begin
			$error("accepted request did not leave the idle state");
			error_count++;
		end

	// ready returns only together with done.
	a_ready_done: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ready) |-> done)
		else begin
			$error("ready returned without a done pulse");
			error_count++;
		end

endmodule

`default_nettype wire

// ==== tb_cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_top;

	import cache_pkg::*;

	localparam int ADDR_WIDTH    = DEF_ADDR_WIDTH;
	localparam int DATA_WIDTH    = DEF_DATA_WIDTH;
	localparam int BLOCK_SIZE    = DEF_BLOCK_SIZE;
	localparam int CACHE_SIZE    = DEF_CACHE_SIZE;
	localparam int MEM_LATENCY   = DEF_MEM_LATENCY;
	localparam int NUM_LINES     = (CACHE_SIZE * 8) / BLOCK_SIZE;
	localparam int OFFSET_WIDTH  = $clog2(BLOCK_SIZE / DATA_WIDTH);
	localparam int INDEX_WIDTH   = $clog2(NUM_LINES);
	localparam int TAG_WIDTH     = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int CLK_PERIOD    = 10;
	localparam int NUM_RANDOM    = 40;
	localparam int MARGIN_CYCLES = 200;

	logic                  clk;
	logic                  rst_n;
	logic                  req;
	logic                  we;
	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  ready;
	logic                  done;
	logic [DATA_WIDTH-1:0] rdata;
	logic                  was_hit;

	// Operation table with expected results.
	logic                  op_we      [$];
	logic [ADDR_WIDTH-1:0] op_addr    [$];
	logic [DATA_WIDTH-1:0] op_wdata   [$];
	logic [DATA_WIDTH-1:0] exp_rdata  [$];
	logic                  exp_hit    [$];
	int                    exp_cycles [$];

	// Reference model of a flat word memory and a direct-mapped tag table.
	logic [DATA_WIDTH-1:0] model_mem   [2**ADDR_WIDTH];
	logic [TAG_WIDTH-1:0]  model_tag   [NUM_LINES];
	logic                  model_valid [NUM_LINES];
	logic                  model_dirty [NUM_LINES];

	integer seed;
	logic   table_built = 1'b0;

	cache_top #(
		.ADDR_WIDTH  (ADDR_WIDTH),
		.DATA_WIDTH  (DATA_WIDTH),
		.BLOCK_SIZE  (BLOCK_SIZE),
		.CACHE_SIZE  (CACHE_SIZE),
		.MEM_LATENCY (MEM_LATENCY)
	) UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (req),
		.we      (we),
		.addr    (addr),
		.wdata   (wdata),
		.ready   (ready),
		.done    (done),
		.rdata   (rdata),
		.was_hit (was_hit)
	);

	bind cache_controller cache_top_props u_props (
		.clk    (clk),
		.rst_n  (rst_n),
		.req    (req),
		.ready  (ready),
		.done   (done),
		.mem_rd (mem_rd),
		.mem_wr (mem_wr),
		.state  (state)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [ADDR_WIDTH-1:0] make_addr(input int tag, input int index,
			input int offset);
		return {TAG_WIDTH'(tag), INDEX_WIDTH'(index), OFFSET_WIDTH'(offset)};
	endfunction

	task automatic check_value(input string name, input logic [DATA_WIDTH-1:0] got,
			input logic [DATA_WIDTH-1:0] expected);
		if (got !== expected) begin
			$display("ERROR: %s got 0x%h, expected 0x%h", name, got, expected);
			$display("Simulation failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < 2**ADDR_WIDTH; i++) begin
			model_mem[i] = '0;
		end
		for (int i = 0; i < NUM_LINES; i++) begin
			model_tag[i]   = '0;
			model_valid[i] = 1'b0;
			model_dirty[i] = 1'b0;
		end
	endtask

	// Runs one access through the model and appends it to the table.
	task automatic add_op(input logic is_write, input logic [ADDR_WIDTH-1:0] a,
			input logic [DATA_WIDTH-1:0] d);
		logic [TAG_WIDTH-1:0] tag;
		int                   index;
		logic                 hit;
		int                   cycles;
		tag   = a[ADDR_WIDTH-1 -: TAG_WIDTH];
		index = a[OFFSET_WIDTH +: INDEX_WIDTH];
		hit   = model_valid[index] && (model_tag[index] == tag);
		if (hit) begin
			cycles = 2;
		end else if (model_dirty[index]) begin
			cycles = 2 + MEM_LATENCY + 2 + MEM_LATENCY + 1;
		end else begin
			cycles = 2 + MEM_LATENCY + 2;
		end
		if (is_write) begin
			model_mem[a] = d;
		end
		if (hit) begin
			model_dirty[index] = model_dirty[index] || is_write;
		end else begin
			model_tag[index]   = tag;
			model_valid[index] = 1'b1;
			model_dirty[index] = is_write;
		end
		op_we.push_back(is_write);
		op_addr.push_back(a);
		op_wdata.push_back(d);
		exp_rdata.push_back(model_mem[a]);
		exp_hit.push_back(hit);
		exp_cycles.push_back(cycles);
	endtask

	task automatic build_directed();
		// Cold miss, then a hit on the same word.
		add_op(1'b0, make_addr(1, 2, 1), '0);
		add_op(1'b0, make_addr(1, 2, 1), '0);
		// Write miss allocates the line.
		add_op(1'b1, make_addr(2, 5, 0), 32'h1111_0000);
		add_op(1'b0, make_addr(2, 5, 0), '0);
		// Write hits on single words.
		add_op(1'b1, make_addr(2, 5, 1), 32'h2222_0001);
		add_op(1'b1, make_addr(2, 5, 3), 32'h3333_0003);
		add_op(1'b1, make_addr(2, 5, 1), 32'h4444_0001);
		for (int w = 0; w < 4; w++) begin
			add_op(1'b0, make_addr(2, 5, w), '0);
		end
		// New tag over the dirty line, then back to the old one.
		add_op(1'b1, make_addr(3, 5, 2), 32'h5555_0002);
		add_op(1'b0, make_addr(2, 5, 1), '0);
		add_op(1'b0, make_addr(2, 5, 3), '0);
		add_op(1'b0, make_addr(3, 5, 2), '0);
		// Clean lines fighting for one index.
		add_op(1'b0, make_addr(2, 5, 0), '0);
		add_op(1'b0, make_addr(3, 5, 2), '0);
		add_op(1'b0, make_addr(2, 5, 2), '0);
		add_op(1'b0, make_addr(3, 5, 0), '0);
		add_op(1'b1, make_addr(6, 7, 3), 32'h6666_0003);
		add_op(1'b0, make_addr(9, 7, 3), '0);
		add_op(1'b0, make_addr(6, 7, 3), '0);
	endtask

	// Few tags over indices 4 to 7, so lines get evicted often.
	task automatic build_random();
		logic [31:0]           r;
		logic [DATA_WIDTH-1:0] d;
		for (int n = 0; n < NUM_RANDOM; n++) begin
			r = $random(seed);
			d = $random(seed);
			add_op(r[0], make_addr(1 + r[2:1], 4 + r[4:3], r[6:5]), d);
		end
	endtask

	task automatic run_op(input int i);
		int cycles;
		while (!ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		req   <= 1'b1;
		we    <= op_we[i];
		addr  <= op_addr[i];
		wdata <= op_wdata[i];
		@(posedge clk);
		req <= 1'b0;
		// Count from the edge that sampled req.
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!done);
		check_value($sformatf("rdata (op %0d)", i), rdata, exp_rdata[i]);
		check_value($sformatf("was_hit (op %0d)", i), DATA_WIDTH'(was_hit),
			DATA_WIDTH'(exp_hit[i]));
		check_value($sformatf("latency (op %0d)", i), cycles, exp_cycles[i]);
	endtask

	initial begin
		rst_n = 1'b0;
		req   = 1'b0;
		we    = 1'b0;
		addr  = '0;
		wdata = '0;
		seed  = 32'h87b4;
		clear_model();
		build_directed();
		build_random();
		table_built = 1'b1;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_value("ready", DATA_WIDTH'(ready), 1);
		check_value("done", DATA_WIDTH'(done), 0);
		check_value("was_hit", DATA_WIDTH'(was_hit), 0);
		check_value("mem_rd", DATA_WIDTH'(UUT.mem_rd), 0);
		check_value("mem_wr", DATA_WIDTH'(UUT.mem_wr), 0);
		check_value("write_en", DATA_WIDTH'(UUT.arr_write_en), 0);
		for (int i = 0; i < op_we.size(); i++) begin
			run_op(i);
		end
		if (UUT.u_ctrl.u_props.error_count != 0) begin
			$display("Protocol assertions failed %0d times",
				UUT.u_ctrl.u_props.error_count);
			$display("Simulation failed");
			$fatal(1, "Assertion failures");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

	// Stop at the first failed protocol assertion.
	initial begin
		wait (UUT.u_ctrl.u_props.error_count != 0);
		$display("A protocol assertion failed at time %0t", $time);
		$display("Simulation failed");
		$fatal(1, "Assertion failure");
	end

	// Worst case per operation is two memory trips plus a few cycles.
	initial begin
		longint limit_cycles;
		wait (table_built);
		limit_cycles = op_we.size() * (2 * MEM_LATENCY + 8) + MARGIN_CYCLES;
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

// ==== cache_top.f ====
cache_pkg.sv
cache_memory.sv
line_word_mux.sv
cache_controller.sv
main_memory.sv
cache_top.sv
cache_top_props.sv
tb_cache_top.sv
